// File: flist.f
+incdir+rtl
rtl/ahb_pkg.sv
rtl/emi_pkg.sv
rtl/smc_access_if.sv
rtl/emi_cycle_if.sv
rtl/smc_ahb_slave.sv
rtl/smc_access_seq.sv
rtl/smc_cycle_engine.sv
rtl/smc_top.sv
tests/tb_smc.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide by the pass line in the output
cd "$(dirname "$0")" \
  && verilator --binary -j 0 -f flist.f --top-module tb_smc -o tb_smc \
  && ./obj_dir/tb_smc | tee /dev/stderr | grep -q "TEST OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: tests/tb_smc.sv
`include "smc_cfg.svh"

module tb_smc;
  timeunit 1ns;
  timeprecision 100ps;
  import ahb_pkg::*;
  import emi_pkg::*;

  logic                   hclk = 1'b0;
  logic                   rst_n;
  logic                   hsel;
  logic [31:0]            haddr;
  htrans_t                htrans;
  hsize_t                 hsize;
  logic                   hwrite;
  logic [31:0]            hwdata;
  logic [31:0]            smc_hrdata;
  logic                   smc_hready;
  logic [`SMC_ADDR_W-2:0] smc_addr;
  half_t                  smc_data;
  half_t                  data_smc;
  logic                   smc_n_cs;
  lane_n_t                smc_n_we;
  logic                   smc_n_oe;
  logic                   smc_busy;

  int                     errors = 0;
  int                     checks = 0;
  logic [31:0]            seed = 32'ha00c;
  half_t                  mem [0:31];     // External SRAM over the 64 byte window
  logic [7:0]             ref_mem [0:63]; // Expected byte image
  logic [`SMC_ADDR_W-2:0] cs_addr_q [$];  // smc_addr at each CS fall
  logic                   p_valid;        // Data phase still open
  logic                   p_write;
  logic                   p_word;
  logic [31:0]            p_want;
  logic [31:0]            p_mask;
  logic [31:0]            p_haddr;
  int                     issued = 0;
  int                     accepted = 0;   // Stalls started by the DUT
  logic                   ready_prev = 1'b1;
  int                     lead_n;
  int                     stb_n;
  int                     trail_n;
  logic                   stb_seen = 1'b0;
  logic                   cs_prev = 1'b1;
  logic                   strobe_low;

  always #4 hclk = ~hclk; // 8 ns period

  smc_top smc_top_i (
    .hclk(hclk), .rst_n(rst_n), .hsel(hsel), .haddr(haddr), .htrans(htrans),
    .hsize(hsize), .hwrite(hwrite), .hwdata(hwdata), .hready(smc_hready),
    .smc_hrdata(smc_hrdata), .smc_hready(smc_hready), .smc_addr(smc_addr),
    .smc_data(smc_data), .data_smc(data_smc), .smc_n_cs(smc_n_cs),
    .smc_n_we(smc_n_we), .smc_n_oe(smc_n_oe), .smc_busy(smc_busy)
  );

  // --------------------------------------------------
  // Memory model and bus monitors
  // --------------------------------------------------
  always @(posedge hclk) begin
    if (!smc_n_cs && !smc_n_we[0]) mem[smc_addr[4:0]][7:0]  <= smc_data[7:0];
    if (!smc_n_cs && !smc_n_we[1]) mem[smc_addr[4:0]][15:8] <= smc_data[15:8];
  end
  assign data_smc   = smc_n_oe ? '0 : mem[smc_addr[4:0]];
  assign strobe_low = !smc_n_oe || (smc_n_we != LANE_NONE);

  // Phase lengths of each external cycle
  always @(negedge hclk) begin
    if (rst_n) begin
      if (ready_prev && !smc_hready) accepted++; // New data phase stall
      ready_prev = smc_hready;
      if (strobe_low && smc_n_cs) begin
        $display("Strobe low while smc_n_cs is high at %0t", $time);
        errors++;
      end
      if (!smc_n_cs) begin
        if (cs_prev) begin // New external cycle
          cs_addr_q.push_back(smc_addr);
          lead_n = 0;
          stb_n = 0;
          trail_n = 0;
          stb_seen = 1'b0;
        end
        if (strobe_low) begin
          stb_n++;
          stb_seen = 1'b1;
        end else if (stb_seen) trail_n++;
        else lead_n++;
      end else if (!cs_prev) begin // CS just released
        chk_word("lead_cycles", 32'(lead_n), 32'(`SMC_CSLE));
        chk_word("strobe_cycles", 32'(stb_n), 32'(`SMC_WS + 1));
        chk_word("trail_cycles", 32'(trail_n), 32'(`SMC_CSTE));
      end
      cs_prev = smc_n_cs;
    end
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a * 37 + 8'h5b); // Differs per byte address
  endfunction

  task automatic chk_word(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL %s got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  task automatic chk_half(input string name, input half_t got, input half_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL %s got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  task automatic chk_bit(input string name, input logic got, input logic want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL %s got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  // Polled at falling edges where smc_hready is stable
  task automatic wait_ready();
    int n;
    n = 0;
    while (!smc_hready && (n < 200)) begin
      @(negedge hclk);
      n++;
    end
    if (!smc_hready) begin
      $display("Timeout, smc_hready stayed low for 200 cycles at %0t", $time);
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("TEST FAILED");
      $finish;
    end
  endtask

  // Ends the open data phase and checks it
  task automatic complete_pending();
    int i;
    wait_ready();
    if (p_valid) begin
      if (!p_write) chk_word("smc_hrdata", smc_hrdata & p_mask, p_want & p_mask);
      chk_word("cs_falls", 32'(cs_addr_q.size()), p_word ? 32'd2 : 32'd1);
      for (i = 0; i < cs_addr_q.size(); i++)
        chk_word("smc_addr", 32'(cs_addr_q[i]), p_haddr + 32'(i)); // Low half first
      cs_addr_q.delete();
      p_valid = 1'b0;
    end
  endtask

  // One AHB transfer whose address phase may overlap the open data phase
  task automatic ahb_transfer(input logic wr, input hsize_t sz, input logic [5:0] a,
                              input logic [31:0] d, input int gap);
    logic [31:0] mask;
    logic [31:0] want;
    int          i;
    hsel   = 1'b1;
    htrans = NONSEQ;
    haddr  = {26'd0, a};
    hsize  = sz;
    hwrite = wr;
    complete_pending(); // Taken at the next rising edge
    case (sz)
      BYTE:    mask = 32'h0000_00ff << (8 * a[1:0]);
      HALF:    mask = 32'h0000_ffff << (8 * a[1:0]);
      default: mask = 32'hffff_ffff;
    endcase
    want = '0;
    for (i = 0; i < 4; i++) begin
      if (mask[8*i]) begin // Little-endian byte lanes
        if (wr) ref_mem[{a[5:2], 2'(i)}] = d[8*i +: 8];
        want[8*i +: 8] = ref_mem[{a[5:2], 2'(i)}];
      end
    end
    @(negedge hclk); // Data phase
    chk_bit("smc_hready", smc_hready, 1'b0); // Stalled while the access runs
    chk_bit("smc_busy", smc_busy, 1'b1);
    hwdata  = wr ? d : lcg_next();
    htrans  = ahb_pkg::IDLE;
    p_valid = 1'b1;
    p_write = wr;
    p_word  = (sz == WORD);
    p_want  = want;
    p_mask  = mask;
    p_haddr = 32'(a[5:1]);
    issued++;
    repeat (gap) @(negedge hclk);
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    logic [31:0] r;
    hsize_t      sz;
    logic [5:0]  a;
    int          i;
    rst_n   = 1'b0;
    hsel    = 1'b0;
    haddr   = '0;
    htrans  = ahb_pkg::IDLE;
    hsize   = WORD;
    hwrite  = 1'b0;
    hwdata  = '0;
    p_valid = 1'b0;
    for (i = 0; i < 32; i++) mem[i] <= {fill_byte(2 * i + 1), fill_byte(2 * i)};
    for (i = 0; i < 64; i++) ref_mem[i] = fill_byte(i);
    repeat (4) @(negedge hclk);
    rst_n = 1'b1;
    @(negedge hclk);
    chk_bit("smc_n_cs", smc_n_cs, 1'b1);
    chk_bit("smc_n_oe", smc_n_oe, 1'b1);
    chk_bit("smc_n_we[0]", smc_n_we[0], 1'b1);
    chk_bit("smc_n_we[1]", smc_n_we[1], 1'b1);
    chk_bit("smc_hready", smc_hready, 1'b1);
    chk_bit("smc_busy", smc_busy, 1'b0);

    // Word writes followed by a read of every word
    for (i = 0; i < 16; i++) begin
      r = lcg_next();
      ahb_transfer(1'b1, WORD, {r[21:18], 2'b00}, lcg_next(), int'(r[25:24]));
    end
    for (i = 0; i < 16; i++)
      ahb_transfer(1'b0, WORD, 6'(4 * i), '0, int'(lcg_next() >> 30));

    // Mixed sizes and directions
    for (i = 0; i < 60; i++) begin
      r = lcg_next();
      case (r[30:29])
        2'd0:    sz = BYTE;
        2'd1:    sz = HALF;
        default: sz = WORD;
      endcase
      a = r[21:16];
      if (sz == HALF) a[0] = 1'b0;
      if (sz == WORD) a[1:0] = 2'b00;
      ahb_transfer(r[31], sz, a, lcg_next(), int'(r[25:24]));
    end
    for (i = 0; i < 16; i++)
      ahb_transfer(1'b0, WORD, 6'(4 * i), '0, 0); // Merged bytes back to back

    complete_pending();
    for (i = 0; i < 32; i++)
      chk_half($sformatf("mem[%0d]", i), mem[i], {ref_mem[2 * i + 1], ref_mem[2 * i]});
    chk_word("accepted", 32'(accepted), 32'(issued)); // Each taken once
    chk_bit("smc_busy", smc_busy, 1'b0);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) $display("TEST OK");
    else $display("TEST FAILED");
    $finish;
  end

endmodule

// File: rtl/smc_top.sv
`include "smc_cfg.svh"

module smc_top (
  input  logic                   hclk,
  input  logic                   rst_n,
  input  logic                   hsel,
  input  logic [31:0]            haddr,
  input  ahb_pkg::htrans_t       htrans,
  input  ahb_pkg::hsize_t        hsize,
  input  logic                   hwrite,
  input  logic [31:0]            hwdata,
  input  logic                   hready,
  output logic [31:0]            smc_hrdata,
  output logic                   smc_hready,
  output logic [`SMC_ADDR_W-2:0] smc_addr,   // Halfword address
  output emi_pkg::half_t         smc_data,
  input  emi_pkg::half_t         data_smc,
  output logic                   smc_n_cs,
  output emi_pkg::lane_n_t       smc_n_we,
  output logic                   smc_n_oe,
  output logic                   smc_busy
);

  smc_access_if acc_if (); // Slave to sequencer
  emi_cycle_if  cyc_if (); // Sequencer to engine

  // AHB side
  smc_ahb_slave ahb_slave_i (
    .hclk       (hclk),
    .rst_n      (rst_n),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hsize      (hsize),
    .hwrite     (hwrite),
    .hwdata     (hwdata),
    .hready     (hready),
    .smc_hrdata (smc_hrdata),
    .smc_hready (smc_hready),
    .acc        (acc_if.master)
  );

  // Word split and read join
  smc_access_seq access_seq_i (
    .hclk     (hclk),
    .rst_n    (rst_n),
    .acc      (acc_if.target),
    .cyc      (cyc_if.master),
    .smc_busy (smc_busy)
  );

  // External bus timing
  smc_cycle_engine cycle_engine_i (
    .hclk     (hclk),
    .rst_n    (rst_n),
    .cyc      (cyc_if.target),
    .smc_addr (smc_addr),
    .smc_data (smc_data),
    .data_smc (data_smc),
    .smc_n_cs (smc_n_cs),
    .smc_n_we (smc_n_we),
    .smc_n_oe (smc_n_oe)
  );

endmodule

// File: rtl/smc_cycle_engine.sv
`include "smc_cfg.svh"

module smc_cycle_engine (
  input  logic                   hclk,
  input  logic                   rst_n,
  emi_cycle_if.target            cyc,
  output logic [`SMC_ADDR_W-2:0] smc_addr,
  output emi_pkg::half_t         smc_data,
  input  emi_pkg::half_t         data_smc,
  output logic                   smc_n_cs,
  output emi_pkg::lane_n_t       smc_n_we,
  output logic                   smc_n_oe
);
  import emi_pkg::*;

  cycle_state_t           state_q;
  logic [`SMC_CNT_W-1:0]  cnt_q;   // Reloaded on every state entry
  logic                   last;    // Final cycle of current state
  logic                   start;
  logic                   enter_strobe;
  logic                   leave_strobe;
  half_t                  rdata_q;

  assign last  = (cnt_q == '0);
  assign start = (state_q == IDLE) && cyc.go;

  assign enter_strobe = (start && (`SMC_CSLE == 0)) ||
                        ((state_q == LEAD) && last);
  assign leave_strobe = (state_q == STROBE) && last;

  // --------------------------------------------------
  // State machine with one down-counter
  // --------------------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (cyc.go) begin
            if (`SMC_CSLE != 0) begin
              state_q <= LEAD;
              cnt_q   <= `SMC_CNT_W'(`SMC_CSLE - 1);
            end else begin
              state_q <= STROBE; // No lead time
              cnt_q   <= `SMC_CNT_W'(`SMC_WS);
            end
          end
        end
        LEAD: begin
          if (last) begin
            state_q <= STROBE;
            cnt_q   <= `SMC_CNT_W'(`SMC_WS); // WS+1 strobe cycles
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        STROBE: begin
          if (!last) begin
            cnt_q <= cnt_q - 1'b1;
          end else if (`SMC_CSTE != 0) begin
            state_q <= TRAIL;
            cnt_q   <= `SMC_CNT_W'(`SMC_CSTE - 1);
          end else begin
            state_q <= IDLE;
          end
        end
        default: begin // TRAIL
          if (last) state_q <= IDLE;
          else      cnt_q   <= cnt_q - 1'b1;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // Registered chip select and strobes
  // --------------------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      smc_n_cs <= 1'b1;
      smc_n_oe <= 1'b1;
      smc_n_we <= LANE_NONE;
    end else begin
      if (start)        smc_n_cs <= 1'b0;
      else if (cyc.fin) smc_n_cs <= 1'b1; // Fin is last CS cycle
      if (enter_strobe) begin
        smc_n_oe <= cyc.write; // Reads only
        smc_n_we <= cyc.write ? cyc.lane_n : LANE_NONE;
      end else if (leave_strobe) begin
        smc_n_oe <= 1'b1;
        smc_n_we <= LANE_NONE;
      end
    end
  end

  // Address and write half held for the whole cycle
  always_ff @(posedge hclk) begin
    if (start) begin
      smc_addr <= cyc.haddr;
      smc_data <= cyc.wdata;
    end
    if (leave_strobe) rdata_q <= data_smc; // Last strobe cycle
  end

  // Fin in trail, or in the strobe end when there is no trail
  assign cyc.fin   = last && ((state_q == TRAIL) ||
                              ((state_q == STROBE) && (`SMC_CSTE == 0)));
  assign cyc.rdata = (state_q == STROBE) ? data_smc : rdata_q;

endmodule

// File: rtl/smc_access_seq.sv
`include "smc_cfg.svh"

module smc_access_seq (
  input  logic         hclk,
  input  logic         rst_n,
  smc_access_if.target acc,
  emi_cycle_if.master  cyc,
  output logic         smc_busy
);
  import ahb_pkg::*;
  import emi_pkg::*;

  logic                   busy_q;
  logic                   go_q;
  logic                   done_q;
  logic                   second_q; // Word, high half in progress
  logic                   word_q;
  logic                   more;     // Another halfword still to go
  logic [`SMC_ADDR_W-2:0] haddr_q;
  logic                   sel_q;    // Which wdata/rdata half
  lane_n_t                lane_n_q;
  logic                   write_q;
  logic [31:0]            wdata_q;
  logic [31:0]            rdata_q;

  assign more = word_q && !second_q;

  // --------------------------------------------------
  // Access control
  // --------------------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      busy_q   <= 1'b0;
      go_q     <= 1'b0;
      done_q   <= 1'b0;
      second_q <= 1'b0;
    end else begin
      go_q   <= 1'b0; // Pulses by default
      done_q <= 1'b0;
      if (acc.start) begin
        busy_q   <= 1'b1;
        go_q     <= 1'b1; // First go one cycle after start
        second_q <= 1'b0;
      end else if (cyc.fin) begin
        if (more) begin
          second_q <= 1'b1;
          go_q     <= 1'b1; // High half right after first fin
        end else begin
          done_q <= 1'b1;
        end
      end
      if (done_q) busy_q <= 1'b0;
    end
  end

  // --------------------------------------------------
  // Halfword address, lanes and data split
  // --------------------------------------------------
  always_ff @(posedge hclk) begin
    if (acc.start) begin
      haddr_q  <= acc.addr[`SMC_ADDR_W-1:1];
      sel_q    <= acc.addr[1];
      word_q   <= (acc.size == WORD);
      write_q  <= acc.write;
      wdata_q  <= acc.wdata;
      if (acc.size == BYTE) lane_n_q <= acc.addr[0] ? LANE_HI : LANE_LO;
      else                  lane_n_q <= LANE_BOTH; // Half and word
    end else if (cyc.fin && more) begin
      haddr_q <= haddr_q + 1'b1; // Next halfword
      sel_q   <= 1'b1;           // Upper data half
    end
  end

  // Join read halves at their address position
  always_ff @(posedge hclk) begin
    if (cyc.fin) begin
      if (sel_q) rdata_q[31:16] <= cyc.rdata;
      else       rdata_q[15:0]  <= cyc.rdata;
    end
  end

  assign cyc.go     = go_q;
  assign cyc.haddr  = haddr_q;
  assign cyc.lane_n = lane_n_q;
  assign cyc.write  = write_q;
  assign cyc.wdata  = sel_q ? wdata_q[31:16] : wdata_q[15:0];

  assign acc.done   = done_q;
  assign acc.rdata  = rdata_q;

  assign smc_busy   = busy_q | acc.start; // Start cycle through done cycle

endmodule

// File: rtl/smc_ahb_slave.sv
`include "smc_cfg.svh"

module smc_ahb_slave (
  input  logic             hclk,
  input  logic             rst_n,
  input  logic             hsel,
  input  logic [31:0]      haddr,
  input  ahb_pkg::htrans_t htrans,
  input  ahb_pkg::hsize_t  hsize,
  input  logic             hwrite,
  input  logic [31:0]      hwdata,
  input  logic             hready,
  output logic [31:0]      smc_hrdata,
  output logic             smc_hready,
  smc_access_if.master     acc
);
  import ahb_pkg::*;

  logic                   accept;   // Address phase taken this edge
  logic                   dphase_q; // First data phase cycle
  logic                   ready_q;  // Registered HREADYOUT
  logic [`SMC_ADDR_W-1:0] addr_q;
  hsize_t                 size_q;
  logic                   write_q;
  logic [31:0]            rdata_q;

  // --------------------------------------------------
  // Address phase
  // --------------------------------------------------
  // IDLE and BUSY fall out here, and nothing is taken while stalled
  assign accept = hsel && hready && ready_q &&
                  ((htrans == NONSEQ) || (htrans == SEQ));

  // Address phase fields, only low address bits reach the bus
  always_ff @(posedge hclk) begin
    if (accept) begin
      addr_q  <= haddr[`SMC_ADDR_W-1:0];
      size_q  <= hsize;
      write_q <= hwrite;
    end
  end

  // --------------------------------------------------
  // Data phase and ready
  // --------------------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      dphase_q <= 1'b0;
      ready_q  <= 1'b1; // Ready out of reset
    end else begin
      dphase_q <= accept; // One cycle pulse
      if (accept) begin
        ready_q <= 1'b0; // Stall whole data phase
      end else if (acc.done) begin
        ready_q <= 1'b1; // Release with read data
      end
    end
  end

  // Read data lands together with ready
  always_ff @(posedge hclk) begin
    if (acc.done) rdata_q <= acc.rdata;
  end

  // Access launch in the data phase
  assign acc.start  = dphase_q;
  assign acc.addr   = addr_q;
  assign acc.size   = size_q;
  assign acc.write  = write_q;
  assign acc.wdata  = hwdata; // Sampled by sequencer on start

  assign smc_hready = ready_q;
  assign smc_hrdata = rdata_q;

endmodule

// File: rtl/emi_cycle_if.sv
`include "smc_cfg.svh"

interface emi_cycle_if;
  import emi_pkg::*;

  logic                   go;    // Starts one external cycle
  logic [`SMC_ADDR_W-2:0] haddr; // Halfword address
  lane_n_t                lane_n;
  logic                   write;
  half_t                  wdata;
  logic                   fin;   // Last cycle of chip select
  half_t                  rdata; // Valid with fin

  // Sequencer side, fields stable from go to fin
  modport master (
    output go, haddr, lane_n, write, wdata,
    input  fin, rdata
  );

  // Cycle engine side
  modport target (
    input  go, haddr, lane_n, write, wdata,
    output fin, rdata
  );

endinterface

// File: rtl/smc_access_if.sv
`include "smc_cfg.svh"

interface smc_access_if;
  import ahb_pkg::*;

  logic                   start; // One cycle, launches an access
  logic [`SMC_ADDR_W-1:0] addr;  // Byte address
  hsize_t                 size;
  logic                   write;
  logic [31:0]            wdata; // AHB lanes, little-endian
  logic                   done;  // One cycle, access finished
  logic [31:0]            rdata; // Valid with done

  // Bus slave side
  modport master (
    output start, addr, size, write, wdata,
    input  done, rdata
  );

  // Access sequencer side
  modport target (
    input  start, addr, size, write, wdata,
    output done, rdata
  );

endinterface

// File: rtl/emi_pkg.sv
`include "smc_cfg.svh"

package emi_pkg;

  // External cycle engine states
  typedef enum logic [1:0] {
    IDLE   = 2'b00, // CS high
    LEAD   = 2'b01, // CS low, strobe not yet
    STROBE = 2'b10, // Strobe low
    TRAIL  = 2'b11  // CS held after strobe
  } cycle_state_t;

  typedef logic [1:0]            lane_n_t; // Byte lanes, active low
  typedef logic [`SMC_BUS_W-1:0] half_t;   // One bus halfword

  // Common lane masks
  localparam lane_n_t LANE_NONE = 2'b11;
  localparam lane_n_t LANE_BOTH = 2'b00;
  localparam lane_n_t LANE_LO   = 2'b10; // Byte 0 only
  localparam lane_n_t LANE_HI   = 2'b01; // Byte 1 only

endpackage

// File: rtl/ahb_pkg.sv
`include "smc_cfg.svh"

package ahb_pkg;

  // AHB transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // Transfer size, only up to a word
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_t;

endpackage

// File: rtl/smc_cfg.svh
`ifndef SMC_CFG_SVH
`define SMC_CFG_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------
`define SMC_ADDR_W 20 // Byte address bits used
`define SMC_BUS_W  16 // External data width

// --------------------------------------------------
// External cycle timing, in hclk cycles
// --------------------------------------------------
`define SMC_CSLE  1 // CS low before strobe, may be 0
`define SMC_WS    2 // Wait states, strobe low WS+1
`define SMC_CSTE  1 // CS low after strobe, may be 0
`define SMC_CNT_W 4 // Timing counter width, holds all of the above

`endif
